//--- common/mem_ctl_pkg.sv
// Shared types and frame widths for the SPI data-memory controller
package mem_ctl_pkg;

    // Widths of the fixed parts of an SPI frame
    localparam int SPI_CMD_W  = 8;
    localparam int SPI_ADDR_W = 24;

    // Core data word
    localparam int DATA_W = 32;

    // RISC-V funct3 access codes for loads and stores
    // Codes not listed here are treated as a full word
    typedef enum logic [2:0] {
        SIZE_B  = 3'b000,
        SIZE_H  = 3'b001,
        SIZE_W  = 3'b010,
        SIZE_BU = 3'b100,
        SIZE_HU = 3'b101
    } mem_size_e;

    // Command byte that opens every SPI frame
    typedef enum logic [SPI_CMD_W-1:0] {
        SPI_WRITE = 8'h02,
        SPI_READ  = 8'h03
    } spi_cmd_e;

    // Access sequencer states
    typedef enum logic [1:0] {
        ST_IDLE    = 2'b00,
        ST_ACTIVE  = 2'b01,
        ST_RESPOND = 2'b10
    } seq_state_e;

endpackage

//--- common/spi_req_if.sv
// Request and result bundle for one SPI transaction between sequencer and engine
interface spi_req_if;
    import mem_ctl_pkg::*;

    // Request side, held by the sequencer until done
    logic                  start;
    logic                  write;
    logic                  flash_sel;
    logic [SPI_ADDR_W-1:0] addr;
    mem_size_e             len;
    logic [DATA_W-1:0]     wdata;

    // Result side, rdata is right-justified and valid with done
    logic [DATA_W-1:0]     rdata;
    logic                  done;

    modport seq (
        output start, write, flash_sel, addr, len, wdata,
        input  rdata, done
    );

    modport engine (
        input  start, write, flash_sel, addr, len, wdata,
        output rdata, done
    );

endinterface

//--- compile.f
common/mem_ctl_pkg.sv
common/spi_req_if.sv
spi/spi_master.sv
rtl/mem_access_seq.sv
rtl/mem_ctl_top.sv
testbench/spi_mem_model.sv
testbench/tb_mem_ctl.sv

//--- rtl/mem_access_seq.sv
// Access sequencer: decodes core requests, serves GPIO and hands SPI work to the engine
module mem_access_seq #(
    parameter logic [31:0] FLASH_SIZE = 32'h0000_2000,
    parameter logic [31:0] GPIO_BASE  = 32'h4000_1000,
    parameter int          GPIO_WIDTH = 5
) (
    input  logic                           clk,
    input  logic                           rst_n,

    input  logic [31:0]                    mem_addr,
    input  logic [mem_ctl_pkg::DATA_W-1:0] mem_wdata,
    input  mem_ctl_pkg::mem_size_e         mem_flag,
    input  logic                           mem_we,
    input  logic                           mem_re,
    output logic [mem_ctl_pkg::DATA_W-1:0] mem_rdata,
    output logic                           mem_ready,

    output logic [GPIO_WIDTH-1:0]          gpio_out,

    spi_req_if.seq                         spi
);
    import mem_ctl_pkg::*;

    seq_state_e state;

    logic req;
    logic idle;
    logic gpio_hit;

    // Byte at the access address goes out first, so lane 0 lands in the top byte
    function automatic logic [DATA_W-1:0] pack_store(input logic [DATA_W-1:0] wdata);
        return {wdata[7:0], wdata[15:8], wdata[23:16], wdata[31:24]};
    endfunction

    // Received bits are right-justified with the first byte highest
    // Reassemble little-endian and zero-extend
    function automatic logic [DATA_W-1:0] unpack_load(
        input logic [DATA_W-1:0] raw,
        input mem_size_e         size
    );
        logic [DATA_W-1:0] value;
        case (size)
            SIZE_B, SIZE_BU: value = {24'h0, raw[7:0]};
            SIZE_H, SIZE_HU: value = {16'h0, raw[7:0], raw[15:8]};
            default:         value = {raw[7:0], raw[15:8], raw[23:16], raw[31:24]};
        endcase
        return value;
    endfunction

    assign req      = mem_we || mem_re;
    assign idle     = (state == ST_IDLE);
    assign gpio_hit = (mem_addr == GPIO_BASE);

    // Control state and the GPIO register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            mem_ready <= 1'b0;
            spi.start <= 1'b0;
            gpio_out  <= '0;
        end else begin
            mem_ready <= 1'b0;
            spi.start <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (req) begin
                        if (gpio_hit) begin
                            // Served locally, answer in the next cycle
                            mem_ready <= 1'b1;
                            if (mem_we) begin
                                gpio_out <= mem_wdata[GPIO_WIDTH-1:0];
                            end
                        end else begin
                            spi.start <= 1'b1;
                            state     <= ST_ACTIVE;
                        end
                    end
                end

                ST_ACTIVE: begin
                    if (spi.done) begin
                        mem_ready <= 1'b1;
                        state     <= ST_RESPOND;
                    end
                end

                // mem_ready is high in this cycle
                ST_RESPOND: begin
                    state <= ST_IDLE;
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Request fields for the engine and the load result
    always_ff @(posedge clk) begin
        if (idle && req && !gpio_hit) begin
            spi.write     <= mem_we;
            spi.flash_sel <= (mem_addr < FLASH_SIZE);
            spi.addr      <= mem_addr[SPI_ADDR_W-1:0];
            spi.len       <= mem_flag;
            spi.wdata     <= pack_store(mem_wdata);
        end

        if (idle && mem_re && gpio_hit) begin
            mem_rdata <= DATA_W'(gpio_out);
        end else if (state == ST_ACTIVE && spi.done && !spi.write) begin
            mem_rdata <= unpack_load(spi.rdata, spi.len);
        end
    end

    // The core must wait for mem_ready before it issues the next request
    a_req_only_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        req |-> idle
    ) else $error("memory request while an access is still in flight");

    a_no_read_and_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(mem_we && mem_re)
    ) else $error("mem_we and mem_re asserted together");

endmodule

//--- rtl/mem_ctl_top.sv
// Data-side memory controller: core load/store requests to SPI Flash, SPI RAM and GPIO
module mem_ctl_top #(
    parameter logic [31:0] FLASH_SIZE  = 32'h0000_2000,
    parameter logic [31:0] GPIO_BASE   = 32'h4000_1000,
    parameter int          GPIO_WIDTH  = 5,
    parameter int          SPI_CLK_DIV = 2
) (
    input  logic                           clk,
    input  logic                           rst_n,

    // Core data port
    input  logic [31:0]                    mem_addr,
    input  logic [mem_ctl_pkg::DATA_W-1:0] mem_wdata,
    input  mem_ctl_pkg::mem_size_e         mem_flag,
    input  logic                           mem_we,
    input  logic                           mem_re,
    output logic [mem_ctl_pkg::DATA_W-1:0] mem_rdata,
    output logic                           mem_ready,

    // GPIO output register
    output logic [GPIO_WIDTH-1:0]          gpio_out,

    // Shared SPI bus with one select per device
    output logic                           flash_cs_n,
    output logic                           ram_cs_n,
    output logic                           spi_sclk,
    output logic                           spi_mosi,
    input  logic                           spi_miso
);

    // Transaction bundle between sequencer and engine
    spi_req_if spi_bus ();

    mem_access_seq #(
        .FLASH_SIZE (FLASH_SIZE),
        .GPIO_BASE  (GPIO_BASE),
        .GPIO_WIDTH (GPIO_WIDTH)
    ) mem_access_seq_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_flag  (mem_flag),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready),
        .gpio_out  (gpio_out),
        .spi       (spi_bus.seq)
    );

    // Serializer for the frame, owns both chip selects
    spi_master #(
        .SPI_CLK_DIV (SPI_CLK_DIV)
    ) spi_master_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .spi_miso   (spi_miso),
        .flash_cs_n (flash_cs_n),
        .ram_cs_n   (ram_cs_n),
        .spi_sclk   (spi_sclk),
        .spi_mosi   (spi_mosi),
        .spi        (spi_bus.engine)
    );

endmodule

//--- spi/spi_master.sv
// SPI mode-0 engine that sends command, address and data and collects read data from miso
module spi_master #(
    parameter int SPI_CLK_DIV = 2
) (
    input  logic     clk,
    input  logic     rst_n,

    input  logic     spi_miso,
    output logic     flash_cs_n,
    output logic     ram_cs_n,
    output logic     spi_sclk,
    output logic     spi_mosi,

    spi_req_if.engine spi
);
    import mem_ctl_pkg::*;

    localparam int HDR_BITS = SPI_CMD_W + SPI_ADDR_W;
    localparam int TX_W     = HDR_BITS + DATA_W;
    localparam int DIV_W    = (SPI_CLK_DIV > 1) ? $clog2(SPI_CLK_DIV) : 1;

    typedef enum logic [1:0] {
        ENG_IDLE   = 2'b00,
        ENG_SHIFT  = 2'b01,
        ENG_FINISH = 2'b10
    } eng_state_e;

    eng_state_e state;

    logic [DIV_W-1:0]  div_cnt;
    logic              div_last;
    logic [6:0]        bit_cnt;
    logic              in_data_phase;
    spi_cmd_e          cmd;
    logic [TX_W-1:0]   tx_sr;
    logic [DATA_W-1:0] rx_sr;

    // Data bits in the frame for a given access size
    function automatic logic [6:0] data_bits(input mem_size_e size);
        logic [6:0] bits;
        case (size)
            SIZE_B, SIZE_BU: bits = 7'd8;
            SIZE_H, SIZE_HU: bits = 7'd16;
            default:         bits = 7'd32;
        endcase
        return bits;
    endfunction

    assign div_last = (div_cnt == DIV_W'(SPI_CLK_DIV - 1));
    assign cmd      = spi.write ? SPI_WRITE : SPI_READ;

    // bit_cnt counts the bits still to go including the current one
    assign in_data_phase = (bit_cnt <= data_bits(spi.len));

    assign spi_mosi  = (state == ENG_SHIFT) ? tx_sr[TX_W-1] : 1'b0;
    assign spi.rdata = rx_sr;

    // Frame control, clock divider and chip selects
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ENG_IDLE;
            div_cnt    <= '0;
            bit_cnt    <= '0;
            spi_sclk   <= 1'b0;
            flash_cs_n <= 1'b1;
            ram_cs_n   <= 1'b1;
            spi.done   <= 1'b0;
        end else begin
            spi.done <= 1'b0;

            case (state)
                ENG_IDLE: begin
                    if (spi.start) begin
                        flash_cs_n <= !spi.flash_sel;
                        ram_cs_n   <= spi.flash_sel;
                        div_cnt    <= '0;
                        bit_cnt    <= 7'(HDR_BITS) + data_bits(spi.len);
                        state      <= ENG_SHIFT;
                    end
                end

                ENG_SHIFT: begin
                    if (div_last) begin
                        div_cnt  <= '0;
                        spi_sclk <= !spi_sclk;
                        // Falling edge closes a bit
                        if (spi_sclk) begin
                            bit_cnt <= bit_cnt - 7'd1;
                            if (bit_cnt == 7'd1) begin
                                flash_cs_n <= 1'b1;
                                ram_cs_n   <= 1'b1;
                                state      <= ENG_FINISH;
                            end
                        end
                    end else begin
                        div_cnt <= div_cnt + DIV_W'(1);
                    end
                end

                ENG_FINISH: begin
                    spi.done <= 1'b1;
                    state    <= ENG_IDLE;
                end

                default: begin
                    state <= ENG_IDLE;
                end
            endcase
        end
    end

    // Shift registers move MSB first in both directions
    always_ff @(posedge clk) begin
        if (state == ENG_IDLE && spi.start) begin
            tx_sr <= {cmd, spi.addr, (spi.write ? spi.wdata : {DATA_W{1'b0}})};
            rx_sr <= '0;
        end else if (state == ENG_SHIFT && div_last) begin
            if (!spi_sclk && in_data_phase && !spi.write) begin
                // Sample on the rising edge
                rx_sr <= {rx_sr[DATA_W-2:0], spi_miso};
            end
            if (spi_sclk) begin
                tx_sr <= {tx_sr[TX_W-2:0], 1'b0};
            end
        end
    end

    // The sequencer may only start a frame while the engine is idle
    a_start_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        spi.start |-> (state == ENG_IDLE)
    ) else $error("SPI start while a frame is in progress");

    // Never both selects low, and a low select must match the held flash_sel
    a_one_select: assert property (
        @(posedge clk) disable iff (!rst_n)
        (flash_cs_n || ram_cs_n) &&
        (flash_cs_n || spi.flash_sel) &&
        (ram_cs_n || !spi.flash_sel)
    ) else $error("chip select low that flash_sel does not choose");

endmodule

//--- testbench/spi_mem_model.sv
// Behavioral SPI memory for one device, answers read and write frames from a sparse byte array
module spi_mem_model #(
    parameter logic [7:0] FILL = 8'h00
) (
    input  logic sclk,
    input  logic cs_n,
    input  logic mosi,
    output wire  miso
);
    timeunit 1ns;
    timeprecision 1ps;
    import mem_ctl_pkg::*;

    localparam int HDR_BITS = SPI_CMD_W + SPI_ADDR_W;

    logic [7:0]          mem [logic [SPI_ADDR_W-1:0]];
    logic [HDR_BITS-1:0] hdr;
    logic [7:0]          rx_byte;
    logic [7:0]          tx_byte;
    logic                miso_q;
    int unsigned         bit_cnt;
    int unsigned         wr_pos;
    int unsigned         rd_pos;

    // Unwritten bytes read back as a pattern of the full address
    function automatic logic [7:0] read_byte(input logic [SPI_ADDR_W-1:0] a);
        logic [7:0] value;
        if (mem.exists(a)) begin
            value = mem[a];
        end else begin
            value = a[7:0] ^ a[15:8] ^ a[23:16] ^ FILL;
        end
        return value;
    endfunction

    assign miso = cs_n ? 1'bz : miso_q;

    always @(negedge cs_n) begin
        bit_cnt = 0;
        miso_q  = 1'b0;
    end

    // Command and address first, then one stored byte per 8 data bits
    always @(posedge sclk) begin
        if (!cs_n) begin
            if (bit_cnt < HDR_BITS) begin
                hdr = {hdr[HDR_BITS-2:0], mosi};
            end else if (hdr[HDR_BITS-1 -: SPI_CMD_W] == SPI_WRITE) begin
                wr_pos  = bit_cnt - HDR_BITS;
                rx_byte = {rx_byte[6:0], mosi};
                if (wr_pos % 8 == 7) begin
                    mem[hdr[SPI_ADDR_W-1:0] + SPI_ADDR_W'(wr_pos / 8)] = rx_byte;
                end
            end
            bit_cnt++;
        end
    end

    // Read data changes after the falling edge, MSB of each byte first
    always @(negedge sclk) begin
        if (!cs_n && bit_cnt >= HDR_BITS && hdr[HDR_BITS-1 -: SPI_CMD_W] == SPI_READ) begin
            rd_pos = bit_cnt - HDR_BITS;
            if (rd_pos % 8 == 0) begin
                tx_byte = read_byte(hdr[SPI_ADDR_W-1:0] + SPI_ADDR_W'(rd_pos / 8));
            end
            miso_q = tx_byte[7 - rd_pos % 8];
        end
    end

endmodule

//--- testbench/tb_mem_ctl.sv
// Testbench for the SPI data-memory controller, random accesses against a reference model
module tb_mem_ctl;
    timeunit 1ns;
    timeprecision 1ps;
    import mem_ctl_pkg::*;

    localparam logic [31:0] FLASH_SIZE  = 32'h0000_2000;
    localparam logic [31:0] GPIO_BASE   = 32'h4000_1000;
    localparam int          GPIO_WIDTH  = 5;
    localparam int          SPI_CLK_DIV = 2;
    localparam int          TIMEOUT     = 2000;
    localparam logic [7:0]  FLASH_FILL  = 8'hc3;
    localparam logic [7:0]  RAM_FILL    = 8'h3c;
    // Small windows so that random accesses overlap
    localparam logic [31:0] FLASH_WIN   = 32'h0000_0100;
    localparam logic [31:0] RAM_WIN     = FLASH_SIZE + 32'h0000_0040;

    logic                  clk;
    logic                  rst_n;
    logic [31:0]           mem_addr;
    logic [31:0]           mem_wdata;
    mem_size_e             mem_flag;
    logic                  mem_we;
    logic                  mem_re;
    logic [31:0]           mem_rdata;
    logic                  mem_ready;
    logic [GPIO_WIDTH-1:0] gpio_out;
    logic                  flash_cs_n;
    logic                  ram_cs_n;
    logic                  spi_sclk;
    logic                  spi_mosi;
    wire                   spi_miso;

    // Reference state
    logic [7:0]            ref_flash [logic [23:0]];
    logic [7:0]            ref_ram [logic [23:0]];
    logic [GPIO_WIDTH-1:0] ref_gpio;
    logic                  flash_seen;
    logic                  ram_seen;

    always #50 clk = ~clk;

    mem_ctl_top #(
        .FLASH_SIZE  (FLASH_SIZE),
        .GPIO_BASE   (GPIO_BASE),
        .GPIO_WIDTH  (GPIO_WIDTH),
        .SPI_CLK_DIV (SPI_CLK_DIV)
    ) mem_ctl_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_flag   (mem_flag),
        .mem_we     (mem_we),
        .mem_re     (mem_re),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready),
        .gpio_out   (gpio_out),
        .flash_cs_n (flash_cs_n),
        .ram_cs_n   (ram_cs_n),
        .spi_sclk   (spi_sclk),
        .spi_mosi   (spi_mosi),
        .spi_miso   (spi_miso)
    );

    spi_mem_model #(.FILL(FLASH_FILL)) flash_model (
        .sclk (spi_sclk),
        .cs_n (flash_cs_n),
        .mosi (spi_mosi),
        .miso (spi_miso)
    );

    spi_mem_model #(.FILL(RAM_FILL)) ram_model (
        .sclk (spi_sclk),
        .cs_n (ram_cs_n),
        .mosi (spi_mosi),
        .miso (spi_miso)
    );

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERR t=%0t: %s, got %h, expected %h", $time, what, actual, expected);
            $display("FAIL: see errors above");
            $fatal(1, "stopping at the first error");
        end
    endtask

    // Bytes moved by a funct3 code, anything unlisted is a word
    function automatic int size_bytes(input logic [2:0] code);
        int n;
        case (code)
            3'b000, 3'b100: n = 1;
            3'b001, 3'b101: n = 2;
            default:        n = 4;
        endcase
        return n;
    endfunction

    function automatic logic [7:0] ref_byte(input logic is_flash, input logic [23:0] a);
        logic [7:0] value;
        value = a[7:0] ^ a[15:8] ^ a[23:16] ^ (is_flash ? FLASH_FILL : RAM_FILL);
        if (is_flash && ref_flash.exists(a)) begin
            value = ref_flash[a];
        end else if (!is_flash && ref_ram.exists(a)) begin
            value = ref_ram[a];
        end
        return value;
    endfunction

    // Little-endian assembly, zero-extended above the access size
    function automatic logic [31:0] ref_load(input logic is_flash, input logic [31:0] addr,
                                             input logic [2:0] code);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < size_bytes(code); i++) begin
            value[8*i +: 8] = ref_byte(is_flash, addr[23:0] + 24'(i));
        end
        return value;
    endfunction

    task automatic ref_store(input logic is_flash, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [2:0] code);
        for (int i = 0; i < size_bytes(code); i++) begin
            if (is_flash) begin
                ref_flash[addr[23:0] + 24'(i)] = wdata[8*i +: 8];
            end else begin
                ref_ram[addr[23:0] + 24'(i)] = wdata[8*i +: 8];
            end
        end
    endtask

    // Region 0 is Flash, 1 is RAM, anything else GPIO
    function automatic logic [31:0] random_addr(input int region, input logic [2:0] code);
        logic [31:0] offset;
        offset = 32'($urandom % 64) & ~32'(size_bytes(code) - 1);
        return (region == 0) ? FLASH_WIN + offset : (region == 1) ? RAM_WIN + offset : GPIO_BASE;
    endfunction

    task automatic run_access(input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [2:0] code,
                              output logic [31:0] rdata, output int cycles);
        @(negedge clk);
        flash_seen = 1'b0;
        ram_seen   = 1'b0;
        mem_addr   = addr;
        mem_wdata  = wdata;
        mem_flag   = mem_size_e'(code);
        mem_we     = write;
        mem_re     = !write;
        @(negedge clk);
        mem_we = 1'b0;
        mem_re = 1'b0;
        cycles = 1;
        while (!mem_ready) begin
            if (cycles >= TIMEOUT) begin
                $display("Timeout: mem_ready never came within %0d cycles for address %h",
                         TIMEOUT, addr);
                $display("FAIL: see errors above");
                $fatal(1, "no response from the DUT");
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
        rdata = mem_rdata;
    endtask

    // One access, checked for data, latency and chip select use
    task automatic checked_access(input logic write, input logic [31:0] addr,
                                  input logic [31:0] wdata, input logic [2:0] code);
        logic [31:0] rdata;
        logic [31:0] expected;
        int          cycles;
        logic        is_gpio;
        logic        is_flash;
        is_gpio  = (addr == GPIO_BASE);
        is_flash = (addr < FLASH_SIZE);
        expected = is_gpio ? 32'(ref_gpio) : ref_load(is_flash, addr, code);
        run_access(write, addr, wdata, code, rdata, cycles);
        if (write && is_gpio) begin
            ref_gpio = wdata[GPIO_WIDTH-1:0];
        end else if (write) begin
            ref_store(is_flash, addr, wdata, code);
        end else begin
            check_value(rdata, expected, $sformatf("load code %b at %h", code, addr));
        end
        if (is_gpio) begin
            check_value(cycles, 1, "GPIO mem_ready latency");
            check_value(gpio_out, ref_gpio, "gpio_out");
            check_value({flash_seen, ram_seen}, 0, "chip select during GPIO access");
        end else begin
            check_value(flash_seen, is_flash, $sformatf("Flash select for %h", addr));
            check_value(ram_seen, !is_flash, $sformatf("RAM select for %h", addr));
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            if (!flash_cs_n) flash_seen = 1'b1;
            if (!ram_cs_n) ram_seen = 1'b1;
            check_value(32'(!flash_cs_n && !ram_cs_n), 0, "both chip selects low");
        end
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        logic [2:0]  code;
        logic [31:0] word_addrs[$];
        void'($urandom(32'h93a4_ed78));
        clk        = 1'b0;
        rst_n      = 1'b0;
        mem_addr   = '0;
        mem_wdata  = '0;
        mem_flag   = SIZE_W;
        mem_we     = 1'b0;
        mem_re     = 1'b0;
        ref_gpio   = '0;
        flash_seen = 1'b0;
        ram_seen   = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        check_value(mem_ready, 0, "mem_ready after reset");
        check_value({flash_cs_n, ram_cs_n}, 2'b11, "chip selects after reset");
        check_value(gpio_out, 0, "gpio_out after reset");
        check_value(spi_sclk, 0, "spi_sclk after reset");
        rst_n = 1'b1;

        // RAM word round trip, model bytes in little-endian order
        for (int i = 0; i < 16; i++) begin
            addr = random_addr(1, 3'b010);
            data = $urandom;
            checked_access(1'b1, addr, data, 3'b010);
            for (int b = 0; b < 4; b++) begin
                check_value(ram_model.read_byte(addr[23:0] + 24'(b)), data[8*b +: 8],
                            "RAM model byte");
            end
            word_addrs.push_back(addr);
        end
        foreach (word_addrs[i]) checked_access(1'b0, word_addrs[i], '0, 3'b010);

        // Sub-word stores, merged word loads, zero-extended sub-word loads
        for (int i = 0; i < 40; i++) begin
            code = {1'($urandom % 2), 1'b0, 1'($urandom % 2)};
            addr = random_addr(1, code);
            checked_access(1'b1, addr, $urandom, code);
            checked_access(1'b0, addr & ~32'h3, '0, 3'b010);
            checked_access(1'b0, addr, '0, {1'($urandom % 2), code[1:0]});
        end

        // Flash region only
        for (int i = 0; i < 20; i++) begin
            code = 3'($urandom);
            addr = random_addr(0, code);
            checked_access(1'b1, addr, $urandom, code);
            checked_access(1'b0, addr, '0, code);
        end

        // GPIO writes and reads
        for (int i = 0; i < 8; i++) begin
            checked_access(1'b1, GPIO_BASE, $urandom, 3'($urandom));
            checked_access(1'b0, GPIO_BASE, '0, 3'($urandom));
        end

        // Random mix over all regions and codes
        for (int i = 0; i < 300; i++) begin
            code = 3'($urandom);
            checked_access(1'($urandom % 2), random_addr($urandom % 3, code), $urandom, code);
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule
